//--- Bender.yml
package:
  name: core

sources:
  - src/core_pkg.sv
  - src/core_fetch.sv
  - src/core_rf.sv
  - src/core_decode.sv
  - src/core_execute.sv
  - src/core_writeback.sv
  - src/core_top.sv
  - target: test
    files:
      - tests/core_tb.sv

//--- list.f
src/core_pkg.sv
src/core_fetch.sv
src/core_rf.sv
src/core_decode.sv
src/core_execute.sv
src/core_writeback.sv
src/core_top.sv
tests/core_tb.sv

//--- src/core_decode.sv
// Decode stage
// Field split, immediate build, control decode and operand
// forwarding into the decode to execute register

`timescale 1ns/1ns

module core_decode (
    input  logic                clk,
    input  logic                rst,

    // From fetch
    input  core_pkg::f_to_d_s   f_to_d,

    // Register file read ports
    output core_pkg::reg_idx_t  rs1_idx,
    output core_pkg::reg_idx_t  rs2_idx,
    input  core_pkg::word_t     rs1_val,
    input  core_pkg::word_t     rs2_val,

    // Results not yet in the register file
    input  core_pkg::fwd_s      e_fwd,
    input  core_pkg::fwd_s      w_fwd,

    // Flush from a taken branch
    input  logic                branch_taken,

    // To execute
    output core_pkg::d_to_e_s   d_to_e
);

    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    d_to_e_s    d_next;

    // Youngest write wins, x0 never forwarded
    function automatic word_t fwd_sel(reg_idx_t idx, word_t rf_val, fwd_s e, fwd_s w);
        word_t v;
        v = rf_val;
        if (idx != '0) begin
            if (e.we && (e.rd == idx)) begin
                v = e.val;
            end else if (w.we && (w.rd == idx)) begin
                v = w.val;
            end
        end
        return v;
    endfunction

    // Instruction fields
    assign opcode  = f_to_d.instr[6:0];
    assign rd      = f_to_d.instr[11:7];
    assign funct3  = f_to_d.instr[14:12];
    assign rs1_idx = f_to_d.instr[19:15];
    assign rs2_idx = f_to_d.instr[24:20];
    assign funct7  = f_to_d.instr[31:25];

    // Immediates, all sign extended from bit 31
    assign imm_i = {{20{f_to_d.instr[31]}}, f_to_d.instr[31:20]};
    assign imm_s = {{20{f_to_d.instr[31]}}, f_to_d.instr[31:25], f_to_d.instr[11:7]};
    assign imm_b = {{19{f_to_d.instr[31]}}, f_to_d.instr[31], f_to_d.instr[7],
                    f_to_d.instr[30:25], f_to_d.instr[11:8], 1'b0};
    assign imm_u = {f_to_d.instr[31:12], 12'h000};

    assign rs1_fwd = fwd_sel(rs1_idx, rs1_val, e_fwd, w_fwd);
    assign rs2_fwd = fwd_sel(rs2_idx, rs2_val, e_fwd, w_fwd);

    always_comb begin
        // Defaults describe a no-op
        d_next            = '0;
        d_next.valid      = f_to_d.valid && !branch_taken;
        d_next.pc         = f_to_d.pc;
        d_next.op_a       = rs1_fwd;
        d_next.op_b       = rs2_fwd;
        d_next.store_data = rs2_fwd;
        d_next.imm        = imm_i;
        d_next.alu_op     = ALU_ADD;
        d_next.rd         = rd;
        unique case (opcode)
            OPC_OP_IMM: begin
                d_next.op_b = imm_i;
                d_next.we   = 1'b1;
                case (funct3)
                    3'b000:  d_next.alu_op = ALU_ADD;
                    3'b111:  d_next.alu_op = ALU_AND;
                    3'b110:  d_next.alu_op = ALU_OR;
                    3'b100:  d_next.alu_op = ALU_XOR;
                    // Shifts and compares not supported
                    default: d_next.we = 1'b0;
                endcase
            end
            OPC_OP: begin
                d_next.we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: d_next.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: d_next.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: d_next.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: d_next.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: d_next.alu_op = ALU_XOR;
                    default:              d_next.we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                d_next.imm    = imm_u;
                d_next.op_b   = imm_u;
                d_next.alu_op = ALU_PASS_B;
                d_next.we     = 1'b1;
            end
            OPC_BRANCH: begin
                d_next.imm = imm_b;
                // BEQ and BNE only
                d_next.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                d_next.bne    = (funct3 == 3'b001);
            end
            OPC_STORE: begin
                d_next.imm   = imm_s;
                // Word stores only
                d_next.store = (funct3 == 3'b010);
            end
            default: ;
        endcase
        // Writes to x0 dropped here
        if (rd == '0) begin
            d_next.we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_to_e.valid <= 1'b0;
        end else begin
            d_to_e <= d_next;
        end
    end

endmodule : core_decode

//--- src/core_execute.sv
// Execute stage
// ALU, store address, BEQ/BNE resolution and flush, plus the
// execute to writeback register

`timescale 1ns/1ns

module core_execute (
    input  logic               clk,
    input  logic               rst,

    // From decode
    input  core_pkg::d_to_e_s  d_to_e,

    // Redirect to fetch, flush to decode
    output logic               branch_taken,
    output core_pkg::word_t    branch_target,

    // Live result for the instruction behind
    output core_pkg::fwd_s     e_fwd,

    // To writeback
    output core_pkg::e_to_w_s  e_to_w
);

    import core_pkg::*;

    word_t alu_result;
    word_t store_addr;
    logic  operands_eq;

    // ALU
    always_comb begin
        case (d_to_e.alu_op)
            ALU_ADD:    alu_result = d_to_e.op_a + d_to_e.op_b;
            ALU_SUB:    alu_result = d_to_e.op_a - d_to_e.op_b;
            ALU_AND:    alu_result = d_to_e.op_a & d_to_e.op_b;
            ALU_OR:     alu_result = d_to_e.op_a | d_to_e.op_b;
            ALU_XOR:    alu_result = d_to_e.op_a ^ d_to_e.op_b;
            ALU_PASS_B: alu_result = d_to_e.op_b;
            default:    alu_result = d_to_e.op_a + d_to_e.op_b;
        endcase
    end

    // Base plus S immediate
    assign store_addr = d_to_e.op_a + d_to_e.imm;

    // Branch compare, BNE inverts the sense
    assign operands_eq   = (d_to_e.op_a == d_to_e.op_b);
    assign branch_taken  = d_to_e.valid && d_to_e.branch && (operands_eq ^ d_to_e.bne);
    assign branch_target = d_to_e.pc + d_to_e.imm;

    // Forward only real register writes
    assign e_fwd.we  = d_to_e.valid && d_to_e.we;
    assign e_fwd.rd  = d_to_e.rd;
    assign e_fwd.val = alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            e_to_w.valid <= 1'b0;
        end else begin
            // The branch itself retires, only younger ones are squashed
            e_to_w.valid <= d_to_e.valid;
        end
        e_to_w.result     <= alu_result;
        e_to_w.store_addr <= store_addr;
        e_to_w.store_data <= d_to_e.store_data;
        e_to_w.rd         <= d_to_e.rd;
        e_to_w.we         <= d_to_e.we;
        e_to_w.store      <= d_to_e.store;
    end

endmodule : core_execute

//--- src/core_fetch.sv
// Fetch stage
// Holds the PC, drives the instruction port and captures the
// returned instruction into the fetch to decode register

`timescale 1ns/1ns

module core_fetch #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    // Clock and reset
    input  logic              clk,
    input  logic              rst,

    // Redirect from execute
    input  logic              branch_taken,
    input  core_pkg::word_t   branch_target,

    // Instruction port, data returns in the same cycle
    output core_pkg::word_t   instr_addr,
    input  core_pkg::instr_t  instr_rdata,

    // To decode
    output core_pkg::f_to_d_s f_to_d
);

    import core_pkg::*;

    word_t pc;
    word_t pc_next;

    // Address goes straight out of the PC register
    assign instr_addr = pc;

    // Sequential flow unless execute redirects
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= RESET_PC;
            f_to_d.valid <= 1'b0;
        end else begin
            pc           <= pc_next;
            // Wrong path fetch is dropped on redirect
            f_to_d.valid <= !branch_taken;
        end
        // Payload needs no reset
        f_to_d.pc    <= pc;
        f_to_d.instr <= instr_rdata;
    end

endmodule : core_fetch

//--- src/core_pkg.sv
// Core package for the four stage RV32I subset core
// Shared widths, opcode constants, ALU operation enum and the
// packed structs carried between pipeline stages

package core_pkg;

    // Widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] instr_t;

    // Major opcodes handled by decode
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU operations, pass-b serves LUI
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // Fetch to decode
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } f_to_d_s;

    // Decode to execute, operands already forwarded
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    op_a;
        word_t    op_b;
        word_t    store_data;
        word_t    imm;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     we;
        logic     store;
        logic     branch;
        logic     bne;
    } d_to_e_s;

    // Execute to writeback
    typedef struct packed {
        logic     valid;
        word_t    result;
        word_t    store_addr;
        word_t    store_data;
        reg_idx_t rd;
        logic     we;
        logic     store;
    } e_to_w_s;

    // Pending register write seen by decode
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    val;
    } fwd_s;

endpackage : core_pkg

//--- src/core_rf.sv
// Integer register file
// 32 entries, two combinational read ports and one write port,
// x0 always reads as zero

`timescale 1ns/1ns

module core_rf (
    input  logic                clk,
    input  logic                rst,

    // Read ports, used by decode
    input  core_pkg::reg_idx_t  rs1_idx,
    input  core_pkg::reg_idx_t  rs2_idx,
    output core_pkg::word_t     rs1_val,
    output core_pkg::word_t     rs2_val,

    // Write port, driven by writeback
    input  logic                rd_we,
    input  core_pkg::reg_idx_t  rd_idx,
    input  core_pkg::word_t     rd_val
);

    import core_pkg::*;

    word_t regs [32];

    // x0 is hardwired to zero
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_val;
        end
    end

endmodule : core_rf

//--- src/core_top.sv
// Top of the four stage core
// Fetch, decode, execute and writeback around a shared register file

`timescale 1ns/1ns

module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    // Clock and reset
    input  logic              clk,
    input  logic              rst,

    // Instruction port
    output core_pkg::word_t   instr_addr,
    input  core_pkg::instr_t  instr_rdata,

    // Store port
    output logic              store_en,
    output core_pkg::word_t   store_addr,
    output core_pkg::word_t   store_data
);

    import core_pkg::*;

    // Inter-stage registers
    f_to_d_s  f_to_d;
    d_to_e_s  d_to_e;
    e_to_w_s  e_to_w;

    // Forwarding sources
    fwd_s     e_fwd;
    fwd_s     w_fwd;

    // Register file ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     rd_we;
    reg_idx_t rd_idx;
    word_t    rd_val;

    // Redirect
    logic     branch_taken;
    word_t    branch_target;

    core_fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_inst (
        .clk           (clk),
        .rst           (rst),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .instr_addr    (instr_addr),
        .instr_rdata   (instr_rdata),
        .f_to_d        (f_to_d)
    );

    core_decode decode_inst (
        .clk          (clk),
        .rst          (rst),
        .f_to_d       (f_to_d),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .e_fwd        (e_fwd),
        .w_fwd        (w_fwd),
        .branch_taken (branch_taken),
        .d_to_e       (d_to_e)
    );

    core_rf rf_inst (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rd_we   (rd_we),
        .rd_idx  (rd_idx),
        .rd_val  (rd_val)
    );

    core_execute execute_inst (
        .clk           (clk),
        .rst           (rst),
        .d_to_e        (d_to_e),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .e_fwd         (e_fwd),
        .e_to_w        (e_to_w)
    );

    core_writeback writeback_inst (
        .clk        (clk),
        .rst        (rst),
        .e_to_w     (e_to_w),
        .rd_we      (rd_we),
        .rd_idx     (rd_idx),
        .rd_val     (rd_val),
        .w_fwd      (w_fwd),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

endmodule : core_top

//--- src/core_writeback.sv
// Writeback stage
// Retires the instruction in the writeback register as either a
// register write or a one-cycle store strobe

`timescale 1ns/1ns

module core_writeback (
    input  logic                clk,
    input  logic                rst,

    // From execute
    input  core_pkg::e_to_w_s   e_to_w,

    // Register file write port
    output logic                rd_we,
    output core_pkg::reg_idx_t  rd_idx,
    output core_pkg::word_t     rd_val,

    // Same write, seen by decode
    output core_pkg::fwd_s      w_fwd,

    // Store port
    output logic                store_en,
    output core_pkg::word_t     store_addr,
    output core_pkg::word_t     store_data
);

    import core_pkg::*;

    // Register write lands at the end of this cycle
    assign rd_we  = e_to_w.valid && e_to_w.we;
    assign rd_idx = e_to_w.rd;
    assign rd_val = e_to_w.result;

    assign w_fwd.we  = rd_we;
    assign w_fwd.rd  = rd_idx;
    assign w_fwd.val = rd_val;

    // One pulse per retired SW
    assign store_en   = e_to_w.valid && e_to_w.store;
    assign store_addr = e_to_w.store_addr;
    assign store_data = e_to_w.store_data;

endmodule : core_writeback

//--- tests/core_tb.sv
// Testbench for the four stage core
// Models instruction memory, assembles a self-checking program and
// checks every store against a queue computed from the ISA rules

`timescale 1ns/1ns

module core_tb;

    import core_pkg::*;

    localparam word_t RESET_PC  = 32'h0000_1000;
    localparam int    MEM_WORDS = 256;

    logic   clk;
    logic   rst;
    word_t  instr_addr;
    instr_t instr_rdata;
    logic   store_en;
    word_t  store_addr;
    word_t  store_data;

    // Program image and architectural model
    instr_t imem [MEM_WORDS];
    int     prog_len;
    logic   prog_ready = 1'b0;
    word_t  model_regs [32];
    string  cur_test;

    // Stores still to come in program order
    word_t  exp_addr [$];
    word_t  exp_data [$];
    string  exp_name [$];

    core_top #(
        .RESET_PC (RESET_PC)
    ) core_top_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instr_rdata (instr_rdata),
        .store_en    (store_en),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic value_mismatch(string test, string what, word_t exp, word_t act);
        abort_run($sformatf("Error: test %s, %s expected %h actual %h", test, what, exp, act));
    endtask

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic instr_t itype(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // No-op past the program with an immediate folded from the whole address
    function automatic instr_t nop_at(word_t a);
        logic [11:0] fold;
        fold = a[11:0] ^ a[23:12] ^ {4'h0, a[31:24]};
        return itype(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, fold);
    endfunction

    function automatic instr_t fetch_word(word_t a);
        word_t off;
        off = a - RESET_PC;
        if ((off < word_t'(4 * prog_len)) && (off[1:0] == 2'b00)) begin
            return imem[off[31:2]];
        end
        return nop_at(a);
    endfunction

    // Same-cycle instruction return
    always_comb instr_rdata = fetch_word(instr_addr);

    task automatic put_word(instr_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // x0 stays zero in the model too
    task automatic write_model(reg_idx_t rd, word_t val);
        if (rd != 5'd0) begin
            model_regs[rd] = val;
        end
    endtask

    task automatic alu_imm(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        word_t a;
        word_t b;
        word_t r;
        a = model_regs[rs1];
        b = sext12(imm);
        case (f3)
            3'b000:  r = a + b;
            3'b111:  r = a & b;
            3'b110:  r = a | b;
            default: r = a ^ b;
        endcase
        put_word(itype(OPC_OP_IMM, f3, rd, rs1, imm));
        write_model(rd, r);
    endtask

    task automatic alu_reg(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                           reg_idx_t rs2);
        word_t a;
        word_t b;
        word_t r;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case ({f7[5], f3})
            4'b0000: r = a + b;
            4'b1000: r = a - b;
            4'b0111: r = a & b;
            4'b0110: r = a | b;
            default: r = a ^ b;
        endcase
        put_word({f7, rs2, rs1, f3, rd, OPC_OP});
        write_model(rd, r);
    endtask

    task automatic load_upper(reg_idx_t rd, logic [19:0] imm);
        put_word({imm, rd, OPC_LUI});
        write_model(rd, {imm, 12'h000});
    endtask

    // Assembles SW and queues only the stores that must appear
    task automatic store_word(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm, bit expected);
        put_word({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
        if (expected) begin
            exp_addr.push_back(model_regs[rs1] + sext12(imm));
            exp_data.push_back(model_regs[rs2]);
            exp_name.push_back(cur_test);
        end
    endtask

    // Branch over two stores that appear only on fall-through
    task automatic branch_pair(bit bne, reg_idx_t rs1, reg_idx_t rs2);
        logic [12:0] off;
        bit          taken;
        off = 13'd12;
        if (bne) begin
            taken = (model_regs[rs1] != model_regs[rs2]);
        end else begin
            taken = (model_regs[rs1] == model_regs[rs2]);
        end
        put_word({off[12], off[10:5], rs2, rs1, {2'b00, bne}, off[4:1], off[11], OPC_BRANCH});
        store_word(rs1, 5'd0, 12'h7f0, !taken);
        store_word(rs2, 5'd0, 12'h7f4, !taken);
    endtask

    // Each op reads results one, two and three instructions back
    // Ops come in pairs with one destination so both forwarding sources
    // can hold the same register
    task automatic build_chain();
        int          d;
        int          d2;
        reg_idx_t    dst;
        reg_idx_t    s1;
        reg_idx_t    s2;
        logic [31:0] rnd;
        reg_idx_t    hist [$];
        hist.push_back(5'd1);
        hist.push_back(5'd2);
        hist.push_back(5'd3);
        for (int i = 0; i < 27; i++) begin
            d   = ((i + i / 9) % 3) + 1;
            d2  = (d % 3) + 1;
            s1  = hist[hist.size() - d];
            s2  = hist[hist.size() - d2];
            dst = reg_idx_t'(12 + ((i / 2) % 8));
            rnd = $urandom();
            case (i % 9)
                0:       alu_reg(7'h00, 3'b000, dst, s1, s2);
                1:       alu_reg(7'h20, 3'b000, dst, s1, s2);
                2:       alu_reg(7'h00, 3'b111, dst, s1, s2);
                3:       alu_reg(7'h00, 3'b110, dst, s1, s2);
                4:       alu_reg(7'h00, 3'b100, dst, s1, s2);
                5:       alu_imm(3'b111, dst, s1, rnd[11:0]);
                6:       alu_imm(3'b110, dst, s1, rnd[11:0]);
                7:       alu_imm(3'b100, dst, s1, rnd[11:0]);
                default: load_upper(dst, rnd[19:0]);
            endcase
            hist.push_back(dst);
        end
        for (int k = 0; k < 8; k++) begin
            store_word(reg_idx_t'(12 + k), 5'd0, 12'h100 + 12'(4 * k), 1'b1);
        end
    endtask

    // Store port checks sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && (store_en === 1'b1)) begin
            if (exp_addr.size() == 0) begin
                abort_run($sformatf("Unexpected store to %h with data %h",
                                    store_addr, store_data));
            end else begin
                assert (store_addr === exp_addr[0])
                else value_mismatch(exp_name[0], "store address", exp_addr[0], store_addr);
                assert (store_data === exp_data[0])
                else value_mismatch(exp_name[0], "store data", exp_data[0], store_data);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    // Watchdog scaled to the program length
    initial begin
        int limit;
        wait (prog_ready === 1'b1);
        limit = 4 * prog_len + 10 + 64;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Run hung: program did not finish within %0d cycles", limit));
    end

    initial begin
        logic [31:0] rnd;
        word_t       exp_pc;
        rst        = 1'b1;
        prog_len   = 0;
        rnd        = $urandom(13);
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        // Random immediates followed by stores to random aligned offsets
        cur_test = "random_imm";
        for (int k = 1; k <= 8; k++) begin
            rnd = $urandom();
            alu_imm(3'b000, reg_idx_t'(k), 5'd0, rnd[11:0]);
        end
        for (int k = 1; k <= 8; k++) begin
            rnd = $urandom();
            store_word(reg_idx_t'(k), 5'd0, {rnd[11:2], 2'b00}, 1'b1);
        end

        cur_test = "dependences";
        build_chain();

        // Writes to x0 right before a store of x0
        cur_test = "x0";
        rnd = $urandom();
        alu_imm(3'b000, 5'd0, 5'd0, rnd[11:0] | 12'h001);
        store_word(5'd0, 5'd0, 12'h200, 1'b1);
        alu_reg(7'h00, 3'b000, 5'd0, 5'd1, 5'd2);
        store_word(5'd0, 5'd0, 12'h204, 1'b1);
        load_upper(5'd0, rnd[31:12] | 20'h00001);
        store_word(5'd0, 5'd0, 12'h208, 1'b1);

        // Taken BEQ and BNE before the two fall-through cases
        cur_test = "branches";
        alu_imm(3'b000, 5'd10, 5'd0, 12'd5);
        alu_imm(3'b000, 5'd11, 5'd0, 12'd9);
        branch_pair(1'b0, 5'd10, 5'd10);
        branch_pair(1'b1, 5'd10, 5'd11);
        branch_pair(1'b0, 5'd10, 5'd11);
        branch_pair(1'b1, 5'd11, 5'd11);
        store_word(5'd10, 5'd0, 12'h300, 1'b1);
        prog_ready = 1'b1;

        // No store may leave during the 10 reset cycles
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            assert (store_en === 1'b0)
            else abort_run("store_en was high while reset was asserted");
        end
        @(posedge clk);
        rst <= 1'b0;

        // First fetches after reset run sequentially from RESET_PC
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            exp_pc = RESET_PC + word_t'(4 * k);
            assert (instr_addr === exp_pc)
            else value_mismatch("reset", "fetch address", exp_pc, instr_addr);
            assert (store_en === 1'b0)
            else abort_run("store_en was high directly after reset");
        end

        // Run until fetch passes the program and let the pipe drain
        while (instr_addr !== (RESET_PC + word_t'(4 * prog_len))) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (exp_addr.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected stores never appeared, first from test %s",
                                exp_addr.size(), exp_name[0]));
        end
    end

endmodule : core_tb
